// File: Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/insn_decode.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/pc_unit.sv
      - source/riscv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_riscv_core.sv

// File: project.f
+incdir+source
source/rv_pkg.sv
source/insn_decode.sv
source/reg_file.sv
source/alu.sv
source/pc_unit.sv
source/riscv_core.sv
testbench/tb_riscv_core.sv

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module alu import rv_pkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  alu_op_e          op,
  input  logic [2:0]       branch_f3,
  output logic [`XLEN-1:0] result,
  output logic             branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = b[4:0];  // Upper bits of b ignored for shifts

  assign eq  = a == b;
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, lt};
      ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, ltu};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $signed(a) >>> shamt;
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;  // LUI
      default:    result = '0;
    endcase
  end

  // Branch compare runs beside the main result
  always_comb begin
    case (branch_f3)
      `F3_BEQ:  branch_taken = eq;
      `F3_BNE:  branch_taken = !eq;
      `F3_BLT:  branch_taken = lt;
      `F3_BGE:  branch_taken = !lt;
      `F3_BLTU: branch_taken = ltu;
      `F3_BGEU: branch_taken = !ltu;
      default:  branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module insn_decode import rv_pkg::*; (
  input  insn_t            insn,
  output ctrl_t            ctrl,
  output logic [`XLEN-1:0] imm
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic             f7_base;
  logic             f7_alt;
  logic             is_ecall;

  // Same funct3 map for register and immediate forms
  function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      `F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      `F3_SLL:  op = ALU_SLL;
      `F3_SLT:  op = ALU_SLT;
      `F3_SLTU: op = ALU_SLTU;
      `F3_XOR:  op = ALU_XOR;
      `F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      `F3_OR:   op = ALU_OR;
      default:  op = ALU_AND;
    endcase
    return op;
  endfunction

  assign imm_i = {{(`XLEN-12){insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
  assign imm_b = {{(`XLEN-13){insn.b_fmt.imm12}}, insn.b_fmt.imm12, insn.b_fmt.imm11,
                  insn.b_fmt.imm10_5, insn.b_fmt.imm4_1, 1'b0};
  assign imm_u = {insn.u_fmt.imm31_12, 12'b0};
  assign imm_j = {{(`XLEN-21){insn.j_fmt.imm20}}, insn.j_fmt.imm20, insn.j_fmt.imm19_12,
                  insn.j_fmt.imm11, insn.j_fmt.imm10_1, 1'b0};

  assign f7_base  = insn.r_fmt.funct7 == `F7_BASE;
  assign f7_alt   = insn.r_fmt.funct7 == `F7_ALT;
  // Everything above the opcode must be zero
  assign is_ecall = insn.i_fmt.imm == 12'd0 && insn.i_fmt.rs1 == '0 &&
                    insn.i_fmt.funct3 == 3'b000 && insn.i_fmt.rd == '0;

  always_comb begin
    ctrl           = '0;
    ctrl.rs1       = insn.r_fmt.rs1;
    ctrl.rs2       = insn.r_fmt.rs2;
    ctrl.rd        = insn.r_fmt.rd;
    ctrl.alu_op    = ALU_ADD;
    ctrl.pc_sel    = PC_SEQ;
    ctrl.branch_f3 = insn.b_fmt.funct3;
    imm            = imm_i;

    case (insn.r_fmt.opcode)
      `OP_LUI: begin
        ctrl.rf_we     = 1'b1;
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = imm_u;
      end
      `OP_AUIPC: begin
        ctrl.rf_we     = 1'b1;
        ctrl.src_a_pc  = 1'b1;
        ctrl.src_b_imm = 1'b1;
        imm            = imm_u;
      end
      `OP_JAL: begin
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = 1'b1;  // Link address
        ctrl.pc_sel = PC_JAL;
        imm         = imm_j;
      end
      `OP_JALR: begin
        if (insn.i_fmt.funct3 == `F3_JALR) begin
          ctrl.rf_we  = 1'b1;
          ctrl.wb_sel = 1'b1;
          ctrl.pc_sel = PC_JALR;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      `OP_BRANCH: begin
        imm = imm_b;
        case (insn.b_fmt.funct3)
          `F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU: ctrl.pc_sel = PC_BRANCH;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      `OP_REG_IMM: begin
        ctrl.src_b_imm = 1'b1;
        ctrl.alu_op    = f3_to_op(insn.i_fmt.funct3, f7_alt);
        // Only the shifts carry a funct7 field
        if (insn.i_fmt.funct3 == `F3_SLL && !f7_base) begin
          ctrl.illegal = 1'b1;
        end else if (insn.i_fmt.funct3 == `F3_SR && !(f7_base || f7_alt)) begin
          ctrl.illegal = 1'b1;
        end else begin
          ctrl.rf_we = 1'b1;
        end
        if (insn.i_fmt.funct3 == `F3_ADD) begin
          ctrl.alu_op = ALU_ADD;  // ADDI has no SUB form
        end
      end
      `OP_REG_REG: begin
        ctrl.alu_op = f3_to_op(insn.r_fmt.funct3, f7_alt);
        if (f7_base || (f7_alt && (insn.r_fmt.funct3 == `F3_ADD ||
                                   insn.r_fmt.funct3 == `F3_SR))) begin
          ctrl.rf_we = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      `OP_MISC_MEM: begin
        // FENCE retires as a no-op
        ctrl.illegal = insn.i_fmt.funct3 != `F3_FENCE;
      end
      `OP_SYSTEM: begin
        if (is_ecall) begin
          ctrl.halt   = 1'b1;
          ctrl.pc_sel = PC_HOLD;  // Park on the ECALL until reset
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  // An unknown encoding must never reach the register file
  always_comb begin
    a_illegal_no_write: assert final (!(ctrl.illegal && ctrl.rf_we))
      else $error("illegal instruction decoded with register write enabled");
  end

endmodule

`default_nettype wire

// File: source/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module pc_unit import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  pc_sel_e          pc_sel,
  input  logic             branch_taken,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] pc
);

  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_rel;    // PC-relative target
  logic [`XLEN-1:0] jalr_sum;
  logic [`XLEN-1:0] pc_next;

  assign pc_plus4 = pc + `XLEN'(4);
  assign pc_rel   = pc + imm;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    case (pc_sel)
      PC_BRANCH: pc_next = branch_taken ? pc_rel : pc_plus4;
      PC_JAL:    pc_next = pc_rel;
      PC_JALR:   pc_next = {jalr_sum[`XLEN-1:1], 1'b0};
      PC_HOLD:   pc_next = pc;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // Aligned offsets must keep the fetch stream aligned
  a_next_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    (pc_sel != PC_HOLD && imm[1:0] == 2'b00 &&
     (pc_sel != PC_JALR || rs1_data[1:0] == 2'b00)) |-> pc_next[1:0] == 2'b00)
    else $error("next PC lost word alignment with an aligned offset");

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module reg_file import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  wb_t                    wb
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.rd != '0) begin  // x0 writes dropped
      regs[wb.rd] <= wb.data;
    end
  end

  // Reads see the value before any write at this edge
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("register x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: source/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module riscv_core import rv_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] pc,
  input  insn_t            insn,
  output wb_t              wb,
  output logic             halt,
  output logic             illegal
);

  ctrl_t            ctrl;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic             branch_taken;
  logic [`XLEN-1:0] link_addr;

  insn_decode u_decode (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  assign alu_a = ctrl.src_a_pc ? pc : rs1_data;   // AUIPC
  assign alu_b = ctrl.src_b_imm ? imm : rs2_data;

  alu u_alu (
    .a            (alu_a),
    .b            (alu_b),
    .op           (ctrl.alu_op),
    .branch_f3    (ctrl.branch_f3),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  pc_unit u_pc (
    .clk          (clk),
    .rst          (rst),
    .pc_sel       (ctrl.pc_sel),
    .branch_taken (branch_taken),
    .imm          (imm),
    .rs1_data     (rs1_data),
    .pc           (pc)
  );

  assign link_addr = pc + `XLEN'(4);

  // Nothing retires while reset is held
  always_comb begin
    wb.en   = ctrl.rf_we && !rst;
    wb.rd   = ctrl.rd;
    wb.data = ctrl.wb_sel ? link_addr : alu_result;
  end

  assign halt    = ctrl.halt && !rst;
  assign illegal = ctrl.illegal;

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("fetch address is not word aligned");

endmodule

`default_nettype wire

// File: source/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and register file geometry
`define XLEN       32
`define NUM_REGS   32
`define REG_ADDR_W 5

// Base opcodes
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_REG_IMM  7'b0010011
`define OP_REG_REG  7'b0110011
`define OP_MISC_MEM 7'b0001111
`define OP_SYSTEM   7'b1110011

// funct3 for the ALU group
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SR    3'b101  // SRL or SRA, split by funct7
`define F3_OR    3'b110
`define F3_AND   3'b111
`define F3_JALR  3'b000
`define F3_FENCE 3'b000

// funct3 for branches
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000  // SUB and SRA

`endif

// File: source/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  // Instruction formats, field order as in the ISA manual
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]             imm_hi;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm_lo;
    logic [6:0]             opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                   imm12;
    logic [5:0]             imm10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm4_1;
    logic                   imm11;
    logic [6:0]             opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]            imm31_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                   imm20;
    logic [9:0]             imm10_1;
    logic                   imm11;
    logic [7:0]             imm19_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } j_fmt_t;

  // One fetched word, seen through every format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR, PC_HOLD
  } pc_sel_e;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    alu_op_e                alu_op;
    logic                   src_b_imm;  // Operand b from immediate
    logic                   src_a_pc;   // Operand a from PC
    logic                   wb_sel;     // 0 ALU result, 1 link address
    logic                   rf_we;
    pc_sel_e                pc_sel;
    logic [2:0]             branch_f3;
    logic                   illegal;
    logic                   halt;
  } ctrl_t;

  typedef struct packed {
    logic                   en;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_t;

endpackage

`default_nettype wire

// File: testbench/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_riscv_core import rv_pkg::*;;

  logic             clk = 1'b0;
  logic             rst;
  logic [`XLEN-1:0] pc;
  insn_t            insn;
  wb_t              wb;
  logic             halt;
  logic             illegal;

  logic [31:0]      prog [$];       // Instruction memory, one word per entry
  int               prog_len = 0;
  int               errors = 0;
  int               cycle = 0;

  // Reference model state and its prediction for the current cycle
  logic [`XLEN-1:0] m_regs [`NUM_REGS];
  logic [`XLEN-1:0] m_pc;
  logic             exp_en;
  logic [4:0]       exp_rd;
  logic [`XLEN-1:0] exp_data;
  logic [`XLEN-1:0] exp_next_pc;
  logic             exp_halt;
  logic             exp_illegal;

  riscv_core dut (
    .clk     (clk),
    .rst     (rst),
    .pc      (pc),
    .insn    (insn),
    .wb      (wb),
    .halt    (halt),
    .illegal (illegal)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG_REG};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
  endfunction

  // Source register from the loaded constants or from earlier results
  function automatic logic [4:0] pick_src(input logic [31:0] r);
    return r[4] ? 5'(16 + r[31:5] % 12) : 5'(r[31:5] % 10);
  endfunction

  // Word at a byte address, zero (an illegal opcode) outside the program
  function automatic logic [31:0] fetch(input logic [`XLEN-1:0] addr);
    if (addr[1:0] != 2'b00 || (addr >> 2) >= prog.size()) return 32'h0;
    return prog[addr >> 2];
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ok(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v - {{20{v[11]}}, v[11:0]};  // ADDI sign-extends the low part
    prog.push_back(enc_u(`OP_LUI, rd, hi[31:12]));
    prog.push_back(enc_i(`OP_REG_IMM, rd, `F3_ADD, rd, v[11:0]));
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] filler;
    logic [2:0]  f3;
    logic [11:0] imm;
    filler = enc_i(`OP_REG_IMM, 5'd13, `F3_ADD, 5'd13, 12'd1);
    prog.push_back(enc_i(`OP_MISC_MEM, 5'd0, `F3_FENCE, 5'd0, 12'h0ff));
    for (int k = 1; k < 9; k++) load_const(5'(k), $urandom);
    prog.push_back(enc_r(`F7_BASE, 5'd0, 5'd1, `F3_ADD, 5'd9));  // x9 copies x1
    for (int k = 0; k < 16; k++) begin
      r = $urandom;
      f3 = r[2:0];
      prog.push_back(enc_r((r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? `F7_ALT : `F7_BASE,
                           pick_src($urandom), pick_src($urandom), f3, 5'(16 + r % 12)));
    end
    for (int k = 0; k < 16; k++) begin
      r = $urandom;
      f3 = r[2:0];
      if (f3 == 3'd1) imm = {7'b0, r[8:4]};
      else if (f3 == 3'd5) imm = {1'b0, r[3], 5'b0, r[8:4]};
      else imm = r[31:20];
      prog.push_back(enc_i(`OP_REG_IMM, 5'(16 + r % 12), f3, pick_src($urandom), imm));
    end
    prog.push_back(enc_i(`OP_REG_IMM, 5'd0, `F3_ADD, 5'd1, 12'd5));  // Dropped x0 write
    prog.push_back(enc_r(`F7_BASE, 5'd1, 5'd0, `F3_ADD, 5'd10));
    r = $urandom;
    prog.push_back(enc_u(`OP_LUI, 5'd11, r[19:0]));
    r = $urandom;
    prog.push_back(enc_u(`OP_AUIPC, 5'd12, r[19:0]));
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      prog.push_back(enc_b(3'(f), 5'd1, 5'd9, 13'd8));  // Equal operands
      prog.push_back(filler);
      prog.push_back(enc_b(3'(f), 5'd1, 5'd2, 13'd8));
      prog.push_back(filler);
      prog.push_back(enc_b(3'(f), 5'd2, 5'd1, 13'd8));  // Same pair swapped
      prog.push_back(filler);
    end
    prog.push_back(enc_j(5'd14, 21'd8));
    prog.push_back(filler);
    prog.push_back(enc_u(`OP_AUIPC, 5'd15, 20'd0));
    prog.push_back(enc_i(`OP_JALR, 5'd16, `F3_JALR, 5'd15, 12'd13));  // Odd target
    prog.push_back(filler);
    prog.push_back(enc_i(`OP_MISC_MEM, 5'd0, `F3_FENCE, 5'd0, 12'h0ff));
    prog.push_back(32'hffff_ffff);
    prog.push_back(enc_i(`OP_SYSTEM, 5'd0, 3'b000, 5'd0, 12'd0));  // ECALL
    prog_len = prog.size();
  endtask

  // Expected outputs for the word at the model PC
  task automatic predict();
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] imm_i;
    w = fetch(m_pc);
    a = m_regs[w[19:15]];
    imm_i = {{20{w[31]}}, w[31:20]};
    exp_en = 1'b0;
    exp_rd = w[11:7];
    exp_data = '0;
    exp_next_pc = m_pc + 32'd4;
    exp_halt = 1'b0;
    exp_illegal = 1'b0;
    case (w[6:0])
      `OP_LUI: {exp_en, exp_data} = {1'b1, w[31:12], 12'b0};
      `OP_AUIPC: {exp_en, exp_data} = {1'b1, m_pc + {w[31:12], 12'b0}};
      `OP_JAL: begin
        {exp_en, exp_data} = {1'b1, m_pc + 32'd4};
        exp_next_pc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      `OP_JALR: begin
        {exp_en, exp_data} = {1'b1, m_pc + 32'd4};
        exp_next_pc = (a + imm_i) & ~32'd1;
      end
      `OP_BRANCH: if (branch_ok(w[14:12], a, m_regs[w[24:20]]))
        exp_next_pc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      `OP_REG_IMM: begin
        exp_en = 1'b1;
        exp_data = alu_ref(w[14:12], w[30] && w[14:12] == 3'd5, a, imm_i);
      end
      `OP_REG_REG: {exp_en, exp_data} = {1'b1, alu_ref(w[14:12], w[30], a, m_regs[w[24:20]])};
      `OP_MISC_MEM: ;
      `OP_SYSTEM: {exp_halt, exp_next_pc} = {1'b1, m_pc};  // Parks on ECALL
      default: exp_illegal = 1'b1;
    endcase
  endtask

  // Retire into the model at the edge, then drive the next fetch
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      m_pc = '0;
      for (int i = 0; i < `NUM_REGS; i++) m_regs[i] = '0;
    end else begin
      if (exp_en && exp_rd != 5'd0) m_regs[exp_rd] = exp_data;
      m_pc = exp_next_pc;
    end
    #1;
    if (cycle == 1) begin
      insn = enc_i(`OP_SYSTEM, 5'd0, 3'b000, 5'd0, 12'd0);  // ECALL while reset is held
    end else begin
      insn = fetch(pc);
    end
    predict();
  end

  // pc is still unknown at the very first edge
  a_reset_state: assert property (@(posedge clk) rst |->
    (!wb.en && !halt && (cycle == 0 || pc == '0)))
    else begin
      errors++;
      $display("core left its reset state while rst was high at %0t", $time);
    end

  a_pc: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
    else begin
      errors++;
      $display("mismatch at %0t: pc expected %h actual %h",
               $time, $sampled(m_pc), $sampled(pc));
    end

  a_wb_en: assert property (@(posedge clk) disable iff (rst) wb.en == exp_en)
    else begin
      errors++;
      $display("mismatch at %0t: wb.en expected %b actual %b",
               $time, $sampled(exp_en), $sampled(wb.en));
    end

  a_wb_rd: assert property (@(posedge clk) disable iff (rst) exp_en |-> wb.rd == exp_rd)
    else begin
      errors++;
      $display("mismatch at %0t: wb.rd expected %0d actual %0d",
               $time, $sampled(exp_rd), $sampled(wb.rd));
    end

  a_wb_data: assert property (@(posedge clk) disable iff (rst) exp_en |-> wb.data == exp_data)
    else begin
      errors++;
      $display("mismatch at %0t: wb.data expected %h actual %h",
               $time, $sampled(exp_data), $sampled(wb.data));
    end

  a_halt: assert property (@(posedge clk) disable iff (rst) halt == exp_halt)
    else begin
      errors++;
      $display("mismatch at %0t: halt expected %b actual %b",
               $time, $sampled(exp_halt), $sampled(halt));
    end

  a_illegal: assert property (@(posedge clk) disable iff (rst) illegal == exp_illegal)
    else begin
      errors++;
      $display("mismatch at %0t: illegal expected %b actual %b",
               $time, $sampled(exp_illegal), $sampled(illegal));
    end

  initial begin
    void'($urandom(32'hc7de));
    rst = 1'b1;
    insn = enc_i(`OP_REG_IMM, 5'd0, `F3_ADD, 5'd0, 12'd0);  // NOP until the first fetch
    build_program();
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    do @(negedge clk); while (!halt);
    repeat (4) @(posedge clk);  // PC must hold on the ECALL
    #2;
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (prog_len != 0);
    #(prog_len * 40 + 1000);
    $display("timeout: core never raised halt, errors so far: %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
